/* bench/fpMulTests.mem */
// Columns are opA opB mode expectedResult expectedFlags in hex
// Mode is the RISC-V frm code and flags hold NV DZ OF UF NX from bit 4 down
3fc00000 40000000 0 40400000 00  // 1.5 x 2.0 is exact in every mode
3fc00000 40000000 1 40400000 00
3fc00000 40000000 2 40400000 00
3fc00000 40000000 3 40400000 00
3fc00000 40000000 4 40400000 00
3f800003 3fc00000 0 3fc00004 01  // Exact tie with an even fraction
3f800003 3fc00000 1 3fc00004 01
3f800003 3fc00000 2 3fc00004 01
3f800003 3fc00000 3 3fc00005 01
3f800003 3fc00000 4 3fc00005 01
bf800003 3fc00000 2 bfc00005 01  // Same tie, negative
bf800003 3fc00000 3 bfc00004 01
bf800003 3fc00000 4 bfc00005 01
3f800001 3fc00000 0 3fc00002 01  // Tie with an odd fraction goes up
3f800001 3f800001 0 3f800002 01  // Only sticky set
3f800001 3f800001 3 3f800003 01
3ffff800 3f800400 0 40000000 01  // All-ones fraction carries into the exponent
3ffff800 3f800400 1 3fffffff 01
7f000000 40000000 0 7f800000 05  // Overflow
7f000000 40000000 1 7f7fffff 05
ff000000 40000000 2 ff800000 05
ff000000 40000000 3 ff7fffff 05
00800000 3f000000 0 00000000 03  // Underflow flushes to zero
80800000 3f000000 0 80000000 03
7f800001 3f800000 0 7fc00000 10  // Signaling NaN
ffc00000 40000000 0 7fc00000 00
7f800000 00000000 0 7fc00000 10  // Infinity times zero
7f800000 c0000000 0 ff800000 00
80400000 40000000 0 80000000 00  // Subnormal input

/* filelist.f */
design/FpMulPkg.sv
design/FpRoundIf.sv
design/FpUnpacker.sv
design/FpSignificandMultiplier.sv
design/FpRounder.sv
design/FpMultiplier.sv
bench/FpMultiplierTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module FpMultiplierTb \
    -Mdir obj_dir -f filelist.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/VFpMultiplierTb > sim.log 2>&1
cat sim.log
grep -qF '*** FAILED ***' sim.log && { echo "Simulation reported failure"; exit 1; }
grep -qF '*** PASSED ***' sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0

/* bench/FpMultiplierTb.sv */
// Self-checking testbench for the pipelined FP multiplier, run from the tests data file
module FpMultiplierTb;
    import FpMulPkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int WIDTH = 32;
    localparam int LATENCY = 3;
    localparam int MAX_TESTS = 64;
    localparam int WORDS_PER_TEST = 5;

    // One outstanding operation
    typedef struct packed {
        int index;
        int issueCycle;
        logic [WIDTH-1:0] result;
        FpFlags flags;
    } Expected;

    logic clk;
    logic arstN;
    logic inValid;
    logic [WIDTH-1:0] opA;
    logic [WIDTH-1:0] opB;
    RoundingMode roundingMode;
    logic outValid;
    logic [WIDTH-1:0] result;
    FpFlags flags;

    // Five words per test: opA, opB, mode, result, flags
    logic [31:0] testWords [0:MAX_TESTS*WORDS_PER_TEST-1];
    Expected expectQ[$];
    int numTests = 0;
    int cycleCount = 0;
    int passCount = 0;
    int failCount = 0;
    int errorCount = 0;
    integer seed;

    FpMultiplier dut0 (
        .clk(clk),
        .arstN(arstN),
        .inValid(inValid),
        .opA(opA),
        .opB(opB),
        .roundingMode(roundingMode),
        .outValid(outValid),
        .result(result),
        .flags(flags)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic compareResult(input int index, input logic [WIDTH-1:0] expected,
                                 input logic [WIDTH-1:0] actual, inout bit ok);
        if (actual !== expected) begin
            $display("ERR test %0d result expected %h actual %h", index, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic compareFlags(input int index, input FpFlags expected,
                                input FpFlags actual, inout bit ok);
        if (actual !== expected) begin
            $display("ERR test %0d flags expected %h actual %h", index, expected, actual);
            ok = 1'b0;
        end
    endtask

    // Outputs change on the rising edge, so they are sampled on the falling one
    always @(negedge clk) begin
        Expected want;
        bit ok;
        int latency;
        if (arstN && outValid) begin
            if (expectQ.size() == 0) begin
                $display("Unexpected result %h with no operation in flight at cycle %0d",
                         result, cycleCount);
                errorCount++;
            end else begin
                want = expectQ.pop_front();
                ok = 1'b1;
                latency = cycleCount - want.issueCycle;
                if (latency != LATENCY) begin
                    $display("Test %0d came out after %0d cycles instead of %0d",
                             want.index, latency, LATENCY);
                    ok = 1'b0;
                end
                compareResult(want.index, want.result, result, ok);
                compareFlags(want.index, want.flags, flags, ok);
                if (ok) begin
                    passCount++;
                    $display("Test %0d ok, result %h flags %h", want.index, result, flags);
                end else begin
                    failCount++;
                    $display("Test %0d wrong", want.index);
                end
            end
        end
    end

    // Stimulus
    initial begin
        Expected entry;
        int i;
        int base;
        int idleCycles;
        seed = 32'hefae3668;
        arstN = 1'b0;
        inValid = 1'b0;
        opA = '0;
        opB = '0;
        roundingMode = FRM_RNE;
        // Unused slots keep an all-ones mode word
        for (i = 0; i < MAX_TESTS * WORDS_PER_TEST; i++) begin
            testWords[i] = '1;
        end
        $readmemh("bench/fpMulTests.mem", testWords);
        while (numTests < MAX_TESTS && testWords[numTests * WORDS_PER_TEST + 2] != '1) begin
            numTests++;
        end
        if (numTests == 0) begin
            $display("No tests were read from the tests file");
            errorCount++;
        end

        repeat (3) begin
            @(negedge clk);
            if (outValid !== 1'b0) begin
                $display("outValid is not low during reset");
                errorCount++;
            end
        end
        arstN = 1'b1;

        for (i = 0; i < numTests; i++) begin
            base = i * WORDS_PER_TEST;
            @(negedge clk);
            inValid = 1'b1;
            opA = testWords[base];
            opB = testWords[base + 1];
            roundingMode = RoundingMode'(testWords[base + 2][2:0]);
            entry.index = i;
            entry.issueCycle = cycleCount;
            entry.result = testWords[base + 3];
            entry.flags = FpFlags'(testWords[base + 4][4:0]);
            expectQ.push_back(entry);
            // Random gaps between operations, zero to two cycles
            idleCycles = {$random(seed)} % 3;
            repeat (idleCycles) begin
                @(negedge clk);
                inValid = 1'b0;
            end
        end
        @(negedge clk);
        inValid = 1'b0;

        // Drain the pipe, then watch a little longer for stray strobes
        while (expectQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (LATENCY + 1) @(negedge clk);

        $display("Tests passed %0d, failed %0d, other errors %0d",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0 && passCount == numTests) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized for reset, the worst-case gaps and the drain
    initial begin
        longint limit;
        #1;
        limit = (longint'(numTests) * 3 + 20) * CLK_PERIOD;
        #(limit);
        $display("Timeout after %0d time units with %0d results outstanding",
                 limit, expectQ.size());
        $display("*** FAILED ***");
        $finish;
    end
endmodule

/* design/FpMultiplier.sv */
// Top level of the three-stage pipelined FP multiplier with RISC-V rounding and flags
module FpMultiplier #(
    parameter int EXPONENT_WIDTH = 8,
    parameter int FRACTION_WIDTH = 23,
    parameter int WIDTH = 1 + EXPONENT_WIDTH + FRACTION_WIDTH
)(
    input  logic clk,
    input  logic arstN,
    input  logic inValid,
    input  logic [WIDTH-1:0] opA,
    input  logic [WIDTH-1:0] opB,
    input  FpMulPkg::RoundingMode roundingMode,
    output logic outValid,
    output logic [WIDTH-1:0] result,
    output FpMulPkg::FpFlags flags
);
    import FpMulPkg::*;

    // Stage 1 input register
    logic s1Valid;
    logic [WIDTH-1:0] s1OpA;
    logic [WIDTH-1:0] s1OpB;
    RoundingMode s1Mode;

    logic signA;
    logic signB;
    logic [EXPONENT_WIDTH-1:0] expA;
    logic [EXPONENT_WIDTH-1:0] expB;
    logic [FRACTION_WIDTH:0] sigA;
    logic [FRACTION_WIDTH:0] sigB;
    FpClass classA;
    FpClass classB;

    logic [WIDTH-1:0] roundedResult;
    FpFlags roundedFlags;
    logic roundedValid;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Valid <= 1'b0;
            s1OpA <= '0;
            s1OpB <= '0;
            s1Mode <= FRM_RNE;
        end else begin
            s1Valid <= inValid;
            s1OpA <= opA;
            s1OpB <= opB;
            s1Mode <= roundingMode;
        end
    end

    FpUnpacker #(.EXPONENT_WIDTH(EXPONENT_WIDTH), .FRACTION_WIDTH(FRACTION_WIDTH)) unpackA (
        .operand(s1OpA), .sign(signA), .exponent(expA), .significand(sigA), .fpClass(classA)
    );

    FpUnpacker #(.EXPONENT_WIDTH(EXPONENT_WIDTH), .FRACTION_WIDTH(FRACTION_WIDTH)) unpackB (
        .operand(s1OpB), .sign(signB), .exponent(expB), .significand(sigB), .fpClass(classB)
    );

    FpRoundIf #(.EXPONENT_WIDTH(EXPONENT_WIDTH), .FRACTION_WIDTH(FRACTION_WIDTH)) roundBus ();

    FpSignificandMultiplier #(
        .EXPONENT_WIDTH(EXPONENT_WIDTH),
        .FRACTION_WIDTH(FRACTION_WIDTH)
    ) mulStage (
        .clk(clk), .arstN(arstN), .valid(s1Valid), .roundingMode(s1Mode),
        .signA(signA), .signB(signB), .expA(expA), .expB(expB),
        .sigA(sigA), .sigB(sigB), .classA(classA), .classB(classB),
        .roundOut(roundBus.producer)
    );

    FpRounder #(.EXPONENT_WIDTH(EXPONENT_WIDTH), .FRACTION_WIDTH(FRACTION_WIDTH)) rounder (
        .roundIn(roundBus.consumer), .result(roundedResult), .flags(roundedFlags),
        .valid(roundedValid)
    );

    // Stage 3 output register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            result <= '0;
            flags <= '0;
        end else begin
            outValid <= roundedValid;
            result <= roundedResult;
            flags <= roundedFlags;
        end
    end
endmodule

/* design/FpRounder.sv */
// Stage 3 of the FP multiplier: rounding in the RISC-V modes, range checks, packing and flags
module FpRounder #(
    parameter int EXPONENT_WIDTH = 8,
    parameter int FRACTION_WIDTH = 23,
    parameter int WIDTH = 1 + EXPONENT_WIDTH + FRACTION_WIDTH
)(
    FpRoundIf.consumer roundIn,
    output logic [WIDTH-1:0] result,
    output FpMulPkg::FpFlags flags,
    output logic valid
);
    import FpMulPkg::*;

    localparam int MAX_EXP = 2 ** EXPONENT_WIDTH - 1;

    logic anyDropped;
    logic increment;
    logic [FRACTION_WIDTH:0] sumFraction;
    logic carry;
    logic [FRACTION_WIDTH-1:0] roundedFraction;
    logic signed [EXPONENT_WIDTH+1:0] roundedExponent;
    logic overflow;
    logic underflow;
    logic towardZero;

    always_comb begin
        anyDropped = roundIn.g || roundIn.r || roundIn.s;
        case (roundIn.roundingMode)
            // Ties go to the even neighbour
            FRM_RNE: increment = roundIn.g && (roundIn.r || roundIn.s || roundIn.fraction[0]);
            FRM_RTZ: increment = 1'b0;
            FRM_RDN: increment = roundIn.sign && anyDropped;
            FRM_RUP: increment = !roundIn.sign && anyDropped;
            FRM_RMM: increment = roundIn.g;
            default: increment = 1'b0;
        endcase
    end

    always_comb begin
        sumFraction = {1'b0, roundIn.fraction} + (FRACTION_WIDTH + 1)'(increment);
        carry = sumFraction[FRACTION_WIDTH];
        // All ones plus one wraps into the next binade
        roundedFraction = sumFraction[FRACTION_WIDTH-1:0];
        roundedExponent = $signed(roundIn.exponent) + (EXPONENT_WIDTH + 2)'(carry);
    end

    always_comb begin
        overflow = (roundedExponent >= MAX_EXP);
        underflow = (roundedExponent <= 0);
        towardZero = (roundIn.roundingMode == FRM_RTZ)
                   || (roundIn.roundingMode == FRM_RDN && !roundIn.sign)
                   || (roundIn.roundingMode == FRM_RUP && roundIn.sign);
    end

    always_comb begin
        flags = '0;
        if (roundIn.special) begin
            result = roundIn.specialResult;
            flags.invalid = roundIn.invalid;
        end else if (overflow) begin
            if (towardZero) begin
                // Largest finite magnitude
                result = {roundIn.sign, {(EXPONENT_WIDTH-1){1'b1}}, 1'b0,
                          {FRACTION_WIDTH{1'b1}}};
            end else begin
                result = {roundIn.sign, {EXPONENT_WIDTH{1'b1}}, {FRACTION_WIDTH{1'b0}}};
            end
            flags.overflow = 1'b1;
            flags.inexact = 1'b1;
        end else if (underflow) begin
            // Flushed to a signed zero
            result = {roundIn.sign, {(WIDTH-1){1'b0}}};
            flags.underflow = 1'b1;
            flags.inexact = 1'b1;
        end else begin
            result = {roundIn.sign, roundedExponent[EXPONENT_WIDTH-1:0], roundedFraction};
            flags.inexact = anyDropped;
        end
    end

    assign valid = roundIn.valid;
endmodule

/* design/FpSignificandMultiplier.sv */
// Stage 2 of the FP multiplier: significand product, exponent sum, normalization, special cases
module FpSignificandMultiplier #(
    parameter int EXPONENT_WIDTH = 8,
    parameter int FRACTION_WIDTH = 23,
    parameter int WIDTH = 1 + EXPONENT_WIDTH + FRACTION_WIDTH
)(
    input  logic clk,
    input  logic arstN,
    input  logic valid,
    input  FpMulPkg::RoundingMode roundingMode,
    input  logic signA,
    input  logic signB,
    input  logic [EXPONENT_WIDTH-1:0] expA,
    input  logic [EXPONENT_WIDTH-1:0] expB,
    input  logic [FRACTION_WIDTH:0] sigA,
    input  logic [FRACTION_WIDTH:0] sigB,
    input  FpMulPkg::FpClass classA,
    input  FpMulPkg::FpClass classB,
    FpRoundIf.producer roundOut
);
    import FpMulPkg::*;

    localparam int BIAS = 2 ** (EXPONENT_WIDTH - 1) - 1;
    localparam int PW = 2 * FRACTION_WIDTH + 2;

    logic productSign;
    logic [PW-1:0] product;
    logic productTop;
    logic [PW-1:0] normProduct;
    logic [EXPONENT_WIDTH+1:0] expSum;
    logic nanA;
    logic nanB;
    logic infA;
    logic infB;
    logic zeroA;
    logic zeroB;
    logic infTimesZero;
    logic isSpecial;
    logic isInvalid;
    logic [WIDTH-1:0] specialWord;

    always_comb begin
        productSign = signA ^ signB;
        product = sigA * sigB;
        // Product of two values in [1,2) lies in [1,4)
        productTop = product[PW-1];
        normProduct = productTop ? product : (product << 1);
        expSum = {2'b00, expA} + {2'b00, expB} - (EXPONENT_WIDTH + 2)'(BIAS)
               + (EXPONENT_WIDTH + 2)'(productTop);
    end

    always_comb begin
        nanA = (classA == FP_QNAN) || (classA == FP_SNAN);
        nanB = (classB == FP_QNAN) || (classB == FP_SNAN);
        infA = (classA == FP_INF);
        infB = (classB == FP_INF);
        zeroA = (classA == FP_ZERO);
        zeroB = (classB == FP_ZERO);
        infTimesZero = (infA && zeroB) || (infB && zeroA);
    end

    always_comb begin
        isSpecial = 1'b1;
        isInvalid = 1'b0;
        specialWord = '0;
        if (nanA || nanB || infTimesZero) begin
            // Canonical quiet NaN
            specialWord = {1'b0, {EXPONENT_WIDTH{1'b1}}, 1'b1, {(FRACTION_WIDTH-1){1'b0}}};
            isInvalid = (classA == FP_SNAN) || (classB == FP_SNAN) || infTimesZero;
        end else if (infA || infB) begin
            specialWord = {productSign, {EXPONENT_WIDTH{1'b1}}, {FRACTION_WIDTH{1'b0}}};
        end else if (zeroA || zeroB) begin
            specialWord = {productSign, {(WIDTH-1){1'b0}}};
        end else begin
            isSpecial = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            roundOut.valid <= 1'b0;
            roundOut.roundingMode <= FRM_RNE;
            roundOut.sign <= 1'b0;
            roundOut.exponent <= '0;
            roundOut.fraction <= '0;
            roundOut.g <= 1'b0;
            roundOut.r <= 1'b0;
            roundOut.s <= 1'b0;
            roundOut.special <= 1'b0;
            roundOut.specialResult <= '0;
            roundOut.invalid <= 1'b0;
        end else begin
            roundOut.valid <= valid;
            roundOut.roundingMode <= roundingMode;
            roundOut.sign <= productSign;
            roundOut.exponent <= expSum;
            // Leading one sits at the top bit after normalization
            roundOut.fraction <= normProduct[PW-2:FRACTION_WIDTH+1];
            roundOut.g <= normProduct[FRACTION_WIDTH];
            roundOut.r <= normProduct[FRACTION_WIDTH-1];
            roundOut.s <= |normProduct[FRACTION_WIDTH-2:0];
            roundOut.special <= isSpecial;
            roundOut.specialResult <= specialWord;
            roundOut.invalid <= isInvalid;
        end
    end
endmodule

/* design/FpUnpacker.sv */
// Field decode and classification of one IEEE-754 operand, used once per multiplier input
module FpUnpacker #(
    parameter int EXPONENT_WIDTH = 8,
    parameter int FRACTION_WIDTH = 23,
    parameter int WIDTH = 1 + EXPONENT_WIDTH + FRACTION_WIDTH
)(
    input  logic [WIDTH-1:0] operand,
    output logic sign,
    output logic [EXPONENT_WIDTH-1:0] exponent,
    output logic [FRACTION_WIDTH:0] significand,
    output FpMulPkg::FpClass fpClass
);
    import FpMulPkg::*;

    logic [FRACTION_WIDTH-1:0] fraction;
    logic expAllZero;
    logic expAllOnes;
    logic fracZero;

    always_comb begin
        sign = operand[WIDTH-1];
        exponent = operand[WIDTH-2:FRACTION_WIDTH];
        fraction = operand[FRACTION_WIDTH-1:0];
    end

    always_comb begin
        expAllZero = (exponent == '0);
        expAllOnes = (exponent == '1);
        fracZero = (fraction == '0);
    end

    always_comb begin
        if (expAllZero) begin
            // Subnormals are flushed, so the fraction is ignored
            fpClass = FP_ZERO;
        end else if (expAllOnes && fracZero) begin
            fpClass = FP_INF;
        end else if (expAllOnes) begin
            // Quiet bit is the top fraction bit
            fpClass = fraction[FRACTION_WIDTH-1] ? FP_QNAN : FP_SNAN;
        end else begin
            fpClass = FP_NORMAL;
        end
    end

    // Hidden bit only for normal numbers
    always_comb begin
        if (expAllZero) begin
            significand = '0;
        end else begin
            significand = {1'b1, fraction};
        end
    end
endmodule

/* design/FpRoundIf.sv */
// Normalized unrounded product passed from the multiplier stage to the rounder
interface FpRoundIf #(
    parameter int EXPONENT_WIDTH = 8,
    parameter int FRACTION_WIDTH = 23,
    parameter int WIDTH = 1 + EXPONENT_WIDTH + FRACTION_WIDTH
);
    import FpMulPkg::*;

    logic valid;
    RoundingMode roundingMode;
    logic sign;
    // Two extra bits, one for overflow headroom and one for the sign
    logic [EXPONENT_WIDTH+1:0] exponent;
    logic [FRACTION_WIDTH-1:0] fraction;
    logic g;
    logic r;
    logic s;
    // Result already fixed by NaN, infinity or zero handling
    logic special;
    logic [WIDTH-1:0] specialResult;
    logic invalid;

    modport producer(output valid, roundingMode, sign, exponent, fraction, g, r, s,
                     special, specialResult, invalid);
    modport consumer(input valid, roundingMode, sign, exponent, fraction, g, r, s,
                     special, specialResult, invalid);
endinterface

/* design/FpMulPkg.sv */
// Shared types for the FP multiplier: rounding modes, operand classes and exception flags
package FpMulPkg;

    // RISC-V frm encodings, the dynamic code 7 is not supported
    typedef enum logic [2:0] {
        FRM_RNE = 3'd0,  // Nearest, ties to even
        FRM_RTZ = 3'd1,  // Toward zero
        FRM_RDN = 3'd2,  // Toward minus infinity
        FRM_RUP = 3'd3,  // Toward plus infinity
        FRM_RMM = 3'd4   // Nearest, ties away from zero
    } RoundingMode;

    // Operand class after unpacking
    // Subnormals are reported as zero
    typedef enum logic [2:0] {
        FP_ZERO,
        FP_NORMAL,
        FP_INF,
        FP_QNAN,
        FP_SNAN
    } FpClass;

    // Same bit order as the RISC-V fflags CSR field
    typedef struct packed {
        logic invalid;    // NV
        logic divByZero;  // DZ, never set by a multiply
        logic overflow;   // OF
        logic underflow;  // UF
        logic inexact;    // NX
    } FpFlags;

endpackage
